// ==== dp_defines.svh ====
`ifndef DP_DEFINES_SVH
`define DP_DEFINES_SVH

// ************************************************************************
// Datapath sizing
// ************************************************************************

// Width of the shared bus and of every word register
`define DP_DATA_WIDTH 32

// General purpose registers R0..R15
`define DP_REG_COUNT 16

// ALU opcode field
`define DP_OP_WIDTH 5

`endif

// ==== dpBusPkg.sv ====
`default_nettype none

`include "dp_defines.svh"

package dpBusPkg;

    // One word on the shared bus
    typedef logic [`DP_DATA_WIDTH-1:0] busWordT;

    // ************************************************************************
    // Strobes that put a register on the bus
    // ************************************************************************
    typedef struct packed {
        logic                     pcOut;
        logic                     zHighOut;
        logic                     zLowOut;
        logic                     mdrOut;
        logic                     hiOut;
        logic                     loOut;
        logic [`DP_REG_COUNT-1:0] regOut;   // One bit per general register
    } busSrcT;

    // Strobes that capture the bus (or memory) on the next edge
    typedef struct packed {
        logic                     pcIn;
        logic                     irIn;
        logic                     marIn;
        logic                     mdrIn;
        logic                     yIn;
        logic                     hiIn;
        logic                     loIn;
        logic                     zIn;
        logic                     read;     // MDR takes memData instead of the bus
        logic [`DP_REG_COUNT-1:0] regIn;
    } busLoadT;

    // Number of sources trying to drive the bus this cycle
    function automatic int unsigned busDriveCount(busSrcT src);
        return $countones({src.pcOut, src.zHighOut, src.zLowOut,
                           src.mdrOut, src.hiOut, src.loOut})
             + $countones(src.regOut);
    endfunction

endpackage

`default_nettype wire

// ==== dpAluPkg.sv ====
`default_nettype none

`include "dp_defines.svh"

package dpAluPkg;

    // Bits needed to express a shift amount
    localparam int unsigned SHAMT_WIDTH = $clog2(`DP_DATA_WIDTH);

    // Full Z width, two bus words
    typedef logic [2*`DP_DATA_WIDTH-1:0] wideWordT;

    typedef enum logic [`DP_OP_WIDTH-1:0] {
        NOP  = 5'b00000,
        ADD  = 5'b00011,
        SUB  = 5'b00100,
        AND  = 5'b00101,
        OR   = 5'b00110,
        SHR  = 5'b00111,
        SHRA = 5'b01000,
        SHL  = 5'b01001,
        ROR  = 5'b01010,
        ROL  = 5'b01011,
        NEG  = 5'b10000,
        NOT  = 5'b10001
    } aluOpT;

    // Output of one execution unit
    typedef struct packed {
        logic     hit;      // Unit owns this operation
        wideWordT value;
    } unitResultT;

    function automatic logic isArithOp(aluOpT op);
        return (op == ADD) || (op == SUB) || (op == NEG);
    endfunction

    function automatic logic isShiftLogicOp(aluOpT op);
        return (op inside {AND, OR, NOT, SHR, SHRA, SHL, ROR, ROL});
    endfunction

endpackage

`default_nettype wire

// ==== registerFile.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dp_defines.svh"

module registerFile (
    input  logic                     Clock,
    input  logic                     arstN,
    input  dpBusPkg::busWordT        bus,
    input  logic [`DP_REG_COUNT-1:0] regIn,
    input  logic [`DP_REG_COUNT-1:0] regOut,
    output dpBusPkg::busWordT        regBus
);
    import dpBusPkg::*;

    busWordT regs [`DP_REG_COUNT];

    // ************************************************************************
    // Register array
    // ************************************************************************
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `DP_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `DP_REG_COUNT; i++) begin
                if (regIn[i]) begin
                    regs[i] <= bus;     // Several may load the same word
                end
            end
        end
    end

    // One-hot read select, zero when nothing is selected
    always_comb begin
        regBus = '0;
        for (int i = 0; i < `DP_REG_COUNT; i++) begin
            if (regOut[i]) begin
                regBus = regBus | regs[i];
            end
        end
    end

    // Two selects would OR words together on the bus
    regOutOneHot: assert property (
        @(posedge Clock) disable iff (!arstN)
        $onehot0(regOut)
    ) else $error("registerFile: regOut not one-hot (%h)", regOut);

endmodule

`default_nettype wire

// ==== arithUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dp_defines.svh"

module arithUnit (
    input  dpBusPkg::busWordT    yReg,
    input  dpBusPkg::busWordT    bus,
    input  dpAluPkg::aluOpT      opcode,
    input  logic                 incPc,
    output dpAluPkg::unitResultT result
);
    import dpBusPkg::*;
    import dpAluPkg::*;

    busWordT opA;
    busWordT opB;
    busWordT sum;
    logic    carryIn;
    logic    signExt;
    logic    own;

    // ************************************************************************
    // Single shared adder
    // ************************************************************************
    //   ADD    y + bus
    //   SUB    y + ~bus + 1
    //   NEG    0 + ~bus + 1
    //   incPc  bus + 1
    always_comb begin
        if (incPc) begin
            opA     = bus;
            opB     = busWordT'(1);
            carryIn = 1'b0;
        end else begin
            opA     = (opcode == NEG) ? '0 : yReg;
            opB     = (opcode == ADD) ? bus : ~bus;
            carryIn = (opcode == SUB) || (opcode == NEG);
        end
    end

    assign sum     = opA + opB + busWordT'(carryIn);
    assign own     = incPc || isArithOp(opcode);
    assign signExt = !incPc && ((opcode == SUB) || (opcode == NEG));

    always_comb begin
        result = '0;
        if (own) begin
            result.hit   = 1'b1;
            result.value = {{`DP_DATA_WIDTH{signExt & sum[`DP_DATA_WIDTH-1]}}, sum};
        end
    end

endmodule

`default_nettype wire

// ==== shiftLogicUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dp_defines.svh"

module shiftLogicUnit (
    input  dpBusPkg::busWordT    yReg,
    input  dpBusPkg::busWordT    bus,
    input  dpAluPkg::aluOpT      opcode,
    output dpAluPkg::unitResultT result
);
    import dpBusPkg::*;
    import dpAluPkg::*;

    logic [SHAMT_WIDTH-1:0] shamt;
    wideWordT               doubled;
    wideWordT               rorWide;
    wideWordT               rolWide;
    busWordT                rorWord;
    busWordT                rolWord;
    busWordT                lowWord;
    logic                   signFill;

    assign shamt = bus[SHAMT_WIDTH-1:0];    // Amount is bus mod 32

    // ************************************************************************
    // Rotates from a doubled copy of Y
    // ************************************************************************
    assign doubled = {yReg, yReg};
    assign rorWide = doubled >> shamt;
    assign rolWide = doubled << shamt;
    assign rorWord = rorWide[`DP_DATA_WIDTH-1:0];
    assign rolWord = rolWide[2*`DP_DATA_WIDTH-1:`DP_DATA_WIDTH];

    always_comb begin
        unique case (opcode)
            AND:     lowWord = yReg & bus;
            OR:      lowWord = yReg | bus;
            NOT:     lowWord = ~bus;                // Bus only
            SHR:     lowWord = yReg >> shamt;
            SHRA:    lowWord = busWordT'($signed(yReg) >>> shamt);
            SHL:     lowWord = yReg << shamt;
            ROR:     lowWord = rorWord;
            ROL:     lowWord = rolWord;
            default: lowWord = '0;
        endcase
    end

    // Only SHRA carries the sign into the upper word
    assign signFill = (opcode == SHRA) && yReg[`DP_DATA_WIDTH-1];

    always_comb begin
        result = '0;
        if (isShiftLogicOp(opcode)) begin
            result.hit   = 1'b1;
            result.value = {{`DP_DATA_WIDTH{signFill}}, lowWord};
        end
    end

endmodule

`default_nettype wire

// ==== resultCombiner.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dp_defines.svh"

module resultCombiner (
    input  logic                 Clock,
    input  logic                 arstN,
    input  logic                 zIn,
    input  dpAluPkg::unitResultT arithResult,
    input  dpAluPkg::unitResultT shiftResult,
    output dpBusPkg::busWordT    zHigh,
    output dpBusPkg::busWordT    zLow
);
    import dpAluPkg::*;

    wideWordT zNext;
    wideWordT zReg;

    // Pick whichever unit claimed the opcode
    always_comb begin
        if (arithResult.hit) begin
            zNext = arithResult.value;
        end else if (shiftResult.hit) begin
            zNext = shiftResult.value;
        end else begin
            zNext = '0;     // NOP or unknown code
        end
    end

    // ************************************************************************
    // Z register
    // ************************************************************************
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            zReg <= '0;
        end else if (zIn) begin
            zReg <= zNext;
        end
    end

    assign zHigh = zReg[2*`DP_DATA_WIDTH-1:`DP_DATA_WIDTH];
    assign zLow  = zReg[`DP_DATA_WIDTH-1:0];

    // Unit decoders must partition the opcode space
    singleHitOnLoad: assert property (
        @(posedge Clock) disable iff (!arstN)
        zIn |-> !(arithResult.hit && shiftResult.hit)
    ) else $error("resultCombiner: both units hit on Z load");

endmodule

`default_nettype wire

// ==== datapath.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dp_defines.svh"

module datapath (
    input  logic              Clock,
    input  logic              arstN,
    input  dpBusPkg::busSrcT  busSrc,
    input  dpBusPkg::busLoadT busLoad,
    input  dpAluPkg::aluOpT   opcode,
    input  logic              incPc,
    input  dpBusPkg::busWordT memData,
    output dpBusPkg::busWordT bus,
    output dpBusPkg::busWordT mar,
    output dpBusPkg::busWordT ir
);
    import dpBusPkg::*;
    import dpAluPkg::*;

    busWordT    pcReg;
    busWordT    irReg;
    busWordT    marReg;
    busWordT    mdrReg;
    busWordT    yReg;
    busWordT    hiReg;
    busWordT    loReg;
    busWordT    mdrNext;
    busWordT    regBus;
    busWordT    zHigh;
    busWordT    zLow;
    unitResultT arithResult;
    unitResultT shiftResult;

    // ************************************************************************
    // Bus multiplexer
    // ************************************************************************
    // AND-OR form, reads zero with no source selected
    always_comb begin
        bus = ({`DP_DATA_WIDTH{busSrc.pcOut}}    & pcReg)
            | ({`DP_DATA_WIDTH{busSrc.zHighOut}} & zHigh)
            | ({`DP_DATA_WIDTH{busSrc.zLowOut}}  & zLow)
            | ({`DP_DATA_WIDTH{busSrc.mdrOut}}   & mdrReg)
            | ({`DP_DATA_WIDTH{busSrc.hiOut}}    & hiReg)
            | ({`DP_DATA_WIDTH{busSrc.loOut}}    & loReg)
            | ({`DP_DATA_WIDTH{|busSrc.regOut}}  & regBus);
    end

    assign mdrNext = busLoad.read ? memData : bus;

    // ************************************************************************
    // Special registers
    // ************************************************************************
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            pcReg  <= '0;
            irReg  <= '0;
            marReg <= '0;
            mdrReg <= '0;
            yReg   <= '0;
            hiReg  <= '0;
            loReg  <= '0;
        end else begin
            if (busLoad.pcIn)  pcReg  <= bus;
            if (busLoad.irIn)  irReg  <= bus;
            if (busLoad.marIn) marReg <= bus;
            if (busLoad.mdrIn) mdrReg <= mdrNext;
            if (busLoad.yIn)   yReg   <= bus;
            if (busLoad.hiIn)  hiReg  <= bus;
            if (busLoad.loIn)  loReg  <= bus;
        end
    end

    assign mar = marReg;
    assign ir  = irReg;

    registerFile u_registerFile (
        .Clock  (Clock),
        .arstN  (arstN),
        .bus    (bus),
        .regIn  (busLoad.regIn),
        .regOut (busSrc.regOut),
        .regBus (regBus)
    );

    // Both units see the same operands and run in parallel
    arithUnit u_arithUnit (
        .yReg   (yReg),
        .bus    (bus),
        .opcode (opcode),
        .incPc  (incPc),
        .result (arithResult)
    );

    shiftLogicUnit u_shiftLogicUnit (
        .yReg   (yReg),
        .bus    (bus),
        .opcode (opcode),
        .result (shiftResult)
    );

    resultCombiner u_resultCombiner (
        .Clock       (Clock),
        .arstN       (arstN),
        .zIn         (busLoad.zIn),
        .arithResult (arithResult),
        .shiftResult (shiftResult),
        .zHigh       (zHigh),
        .zLow        (zLow)
    );

    // Register file and special registers share one bus
    singleBusDriver: assert property (
        @(posedge Clock) disable iff (!arstN)
        busDriveCount(busSrc) <= 1
    ) else $error("datapath: %0d bus drivers active", busDriveCount(busSrc));

endmodule

`default_nettype wire

// ==== datapath_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "dp_defines.svh"

module datapath_tb;
    import dpBusPkg::*;
    import dpAluPkg::*;

    localparam int      AMT_BITS      = $clog2(`DP_DATA_WIDTH);
    localparam int      SEQUENCES     = 61;
    localparam int      SEQ_CYCLES    = 12;     // Longest sequence plus slack
    localparam int      WATCHDOG_NS   = (SEQUENCES * SEQ_CYCLES + 50) * 4;
    localparam busWordT ALL_ONES      = '1;
    localparam aluOpT   ARITH_OPS [3] = '{ADD, SUB, NEG};
    localparam aluOpT   SHIFT_OPS [8] = '{AND, OR, NOT, SHR, SHRA, SHL, ROR, ROL};

    logic     Clock;
    logic     arstN;
    busSrcT   busSrc;
    busLoadT  busLoad;
    aluOpT    opcode;
    logic     incPc;
    busWordT  memData;
    busWordT  bus;
    busWordT  mar;
    busWordT  ir;
    integer   seed;
    int       busErrors;
    int       marErrors;
    int       irErrors;

    // Reference model state as it stands after the last rising edge
    busWordT  modelRegs [`DP_REG_COUNT];
    busWordT  modelPc;
    busWordT  modelIr;
    busWordT  modelMar;
    busWordT  modelMdr;
    busWordT  modelY;
    busWordT  modelHi;
    busWordT  modelLo;
    wideWordT modelZ;
    busWordT  modelBusVal;
    busLoadT  pendLoad;     // Strobes of the running cycle
    busWordT  pendMem;
    wideWordT pendZ;

    datapath u_dut (
        .Clock   (Clock),
        .arstN   (arstN),
        .busSrc  (busSrc),
        .busLoad (busLoad),
        .opcode  (opcode),
        .incPc   (incPc),
        .memData (memData),
        .bus     (bus),
        .mar     (mar),
        .ir      (ir)
    );

    always #2 Clock = ~Clock;

    // ************************************************************************
    // Reference model
    // ************************************************************************
    function automatic busWordT predictBus(input busSrcT src);
        busWordT w;
        w = '0;
        if (src.pcOut)    w = w | modelPc;
        if (src.zHighOut) w = w | modelZ[2*`DP_DATA_WIDTH-1:`DP_DATA_WIDTH];
        if (src.zLowOut)  w = w | modelZ[`DP_DATA_WIDTH-1:0];
        if (src.mdrOut)   w = w | modelMdr;
        if (src.hiOut)    w = w | modelHi;
        if (src.loOut)    w = w | modelLo;
        for (int i = 0; i < `DP_REG_COUNT; i++) begin
            if (src.regOut[i]) w = w | modelRegs[i];
        end
        return w;
    endfunction

    function automatic wideWordT computeAlu(input aluOpT op, input logic inc,
                                            input busWordT y, input busWordT b);
        logic [AMT_BITS-1:0] n;
        logic [AMT_BITS-1:0] nComp;
        busWordT             w;
        busWordT             upper;
        n     = b[AMT_BITS-1:0];
        nComp = -n;     // Opposite amount closes a rotate
        upper = '0;
        if (inc) begin
            w = b + 1;
        end else begin
            case (op)
                ADD:     w = y + b;
                SUB:     w = y - b;
                NEG:     w = -b;
                AND:     w = y & b;
                OR:      w = y | b;
                NOT:     w = ~b;
                SHR:     w = y >> n;
                SHRA:    w = (y >> n) | (y[`DP_DATA_WIDTH-1] ? ~(ALL_ONES >> n) : '0);
                SHL:     w = y << n;
                ROR:     w = (y >> n) | (y << nComp);
                ROL:     w = (y << n) | (y >> nComp);
                default: w = '0;
            endcase
            if (op == SUB || op == NEG || op == SHRA) begin
                upper = {`DP_DATA_WIDTH{w[`DP_DATA_WIDTH-1]}};
            end
        end
        return {upper, w};
    endfunction

    function automatic void commitLoads();
        if (pendLoad.pcIn)  modelPc  = modelBusVal;
        if (pendLoad.irIn)  modelIr  = modelBusVal;
        if (pendLoad.marIn) modelMar = modelBusVal;
        if (pendLoad.mdrIn) modelMdr = pendLoad.read ? pendMem : modelBusVal;
        if (pendLoad.yIn)   modelY   = modelBusVal;
        if (pendLoad.hiIn)  modelHi  = modelBusVal;
        if (pendLoad.loIn)  modelLo  = modelBusVal;
        if (pendLoad.zIn)   modelZ   = pendZ;
        for (int i = 0; i < `DP_REG_COUNT; i++) begin
            if (pendLoad.regIn[i]) modelRegs[i] = modelBusVal;
        end
    endfunction

    function automatic busSrcT regSrc(input int r);
        busSrcT s;
        s = '0;
        s.regOut[r] = 1'b1;
        return s;
    endfunction

    function automatic busLoadT regLoad(input int r);
        busLoadT l;
        l = '0;
        l.regIn[r] = 1'b1;
        return l;
    endfunction

    function automatic busWordT nextRandomWord();
        return $random(seed);
    endfunction

    // ************************************************************************
    // Stimulus
    // ************************************************************************
    // One bus cycle driven on the falling edge
    task automatic step(input busSrcT src, input busLoadT ld, input aluOpT op,
                        input logic inc, input busWordT mem);
        @(negedge Clock);
        commitLoads();
        busSrc      = src;
        busLoad     = ld;
        opcode      = op;
        incPc       = inc;
        memData     = mem;
        modelBusVal = predictBus(src);
        pendLoad    = ld;
        pendMem     = mem;
        pendZ       = computeAlu(op, inc, modelY, modelBusVal);
    endtask

    task automatic loadFromMemory(input int r, input busWordT word);
        step('0, busLoadT'{mdrIn: 1'b1, read: 1'b1, default: '0}, NOP, 1'b0, word);
        step(busSrcT'{mdrOut: 1'b1, default: '0}, regLoad(r), NOP, 1'b0, '0);
    endtask

    // R1 to Y, R2 with the opcode into Z, Z low to R3, then Z high and R3 on the bus
    task automatic runAluCase(input aluOpT op, input busWordT a, input busWordT b);
        loadFromMemory(1, a);
        loadFromMemory(2, b);
        step(regSrc(1), busLoadT'{yIn: 1'b1, default: '0}, NOP, 1'b0, '0);
        step(regSrc(2), busLoadT'{zIn: 1'b1, default: '0}, op, 1'b0, '0);
        step(busSrcT'{zLowOut: 1'b1, default: '0}, regLoad(3), NOP, 1'b0, '0);
        step(busSrcT'{zHighOut: 1'b1, default: '0}, '0, NOP, 1'b0, '0);
        step(regSrc(3), '0, NOP, 1'b0, '0);
    endtask

    busMatch: assert property (@(posedge Clock) disable iff (!arstN) bus == modelBusVal)
    else begin
        busErrors++;
        $display("ERROR bus: got %h expected %h", $sampled(bus), $sampled(modelBusVal));
    end

    marMatch: assert property (@(posedge Clock) disable iff (!arstN) mar == modelMar)
    else begin
        marErrors++;
        $display("ERROR mar: got %h expected %h", $sampled(mar), $sampled(modelMar));
    end

    irMatch: assert property (@(posedge Clock) disable iff (!arstN) ir == modelIr)
    else begin
        irErrors++;
        $display("ERROR ir: got %h expected %h", $sampled(ir), $sampled(modelIr));
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the test sequences completed");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        Clock       = 1'b0;
        arstN       = 1'b0;
        busSrc      = '0;
        busLoad     = '0;
        opcode      = NOP;
        incPc       = 1'b0;
        memData     = '0;
        seed        = 32'hd0b2_38b4;
        busErrors   = 0;
        marErrors   = 0;
        irErrors    = 0;
        modelPc     = '0;
        modelIr     = '0;
        modelMar    = '0;
        modelMdr    = '0;
        modelY      = '0;
        modelHi     = '0;
        modelLo     = '0;
        modelZ      = '0;
        modelBusVal = '0;
        pendLoad    = '0;
        pendMem     = '0;
        pendZ       = '0;
        for (int i = 0; i < `DP_REG_COUNT; i++) begin
            modelRegs[i] = '0;
        end
        repeat (3) @(posedge Clock);
        @(negedge Clock);
        arstN = 1'b1;

        step('0, '0, NOP, 1'b0, '0);    // Bus, mar and ir at zero
        for (int r = 0; r < `DP_REG_COUNT; r++) begin
            loadFromMemory(r, nextRandomWord());
            step(regSrc(r), '0, NOP, 1'b0, '0);
        end

        for (int k = 0; k < 3; k++) begin
            runAluCase(ARITH_OPS[k], nextRandomWord(), nextRandomWord());
            runAluCase(ARITH_OPS[k], 32'h0000_0005, 32'h0000_0009);
            runAluCase(ARITH_OPS[k], nextRandomWord(), nextRandomWord());
        end
        for (int k = 0; k < 8; k++) begin
            runAluCase(SHIFT_OPS[k], nextRandomWord(), 32'd0);
            runAluCase(SHIFT_OPS[k], nextRandomWord(), 32'd31);
            runAluCase(SHIFT_OPS[k], nextRandomWord(), nextRandomWord());
            runAluCase(SHIFT_OPS[k], nextRandomWord(), nextRandomWord());
        end

        // PC increment through Z, then PC into MAR
        loadFromMemory(5, nextRandomWord());
        step(regSrc(5), busLoadT'{pcIn: 1'b1, default: '0}, NOP, 1'b0, '0);
        step(busSrcT'{pcOut: 1'b1, default: '0},
             busLoadT'{zIn: 1'b1, default: '0}, NOP, 1'b1, '0);
        step(busSrcT'{zLowOut: 1'b1, default: '0},
             busLoadT'{pcIn: 1'b1, default: '0}, NOP, 1'b0, '0);
        step(busSrcT'{pcOut: 1'b1, default: '0},
             busLoadT'{marIn: 1'b1, default: '0}, NOP, 1'b0, '0);

        loadFromMemory(6, nextRandomWord());
        loadFromMemory(7, nextRandomWord());
        step(regSrc(6), busLoadT'{hiIn: 1'b1, default: '0}, NOP, 1'b0, '0);
        step(regSrc(7), busLoadT'{loIn: 1'b1, default: '0}, NOP, 1'b0, '0);
        step(busSrcT'{hiOut: 1'b1, default: '0}, '0, NOP, 1'b0, '0);
        step(busSrcT'{loOut: 1'b1, default: '0}, '0, NOP, 1'b0, '0);
        step('0, busLoadT'{mdrIn: 1'b1, read: 1'b1, default: '0}, NOP, 1'b0, nextRandomWord());
        step(busSrcT'{mdrOut: 1'b1, default: '0}, busLoadT'{irIn: 1'b1, default: '0}, NOP, 1'b0, '0);
        step('0, '0, NOP, 1'b0, '0);
        step('0, '0, NOP, 1'b0, '0);
        @(negedge Clock);

        $display("Check summary: bus errors %0d, mar errors %0d, ir errors %0d",
                 busErrors, marErrors, irErrors);
        if (busErrors + marErrors + irErrors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
dpBusPkg.sv
dpAluPkg.sv
registerFile.sv
arithUnit.sv
shiftLogicUnit.sv
resultCombiner.sv
datapath.sv
datapath_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the datapath testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/100ps --top-module datapath_tb -f files.f || exit 1
./obj_dir/Vdatapath_tb > sim.log 2>&1 || { cat sim.log; echo "Simulation aborted"; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; } || echo "Simulation passed"
